//--- logic/cc_pkg.sv
package cc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths with a meaning
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] gap_t;      // cycles between admissions
    typedef logic [10:0] alpha_t;    // fixed point, 1024 == 1.0
    typedef logic [63:0] req_t;      // request descriptor, opaque here
    typedef logic [2:0]  cfg_addr_t;
    typedef logic [31:0] cfg_data_t;
    typedef logic [3:0]  shift_t;    // gain exponent g

    typedef enum logic [0:0] {
        ST_WAIT_GAP = 1'b0,          // timer running, waiting for gap + request + space
        ST_ADMIT    = 1'b1           // one cycle, hands the request to the queue
    } pacer_state_t;

    localparam alpha_t ALPHA_ONE = 11'd1024;

    // request queue
    localparam int REQ_QDEPTH = 16;
    localparam int REQ_PTR_W  = $clog2(REQ_QDEPTH);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam cfg_addr_t REG_INIT_GAP    = 3'd0;  // rw
    localparam cfg_addr_t REG_MIN_GAP     = 3'd1;  // rw
    localparam cfg_addr_t REG_MAX_GAP     = 3'd2;  // rw
    localparam cfg_addr_t REG_RECOVER_CNT = 3'd3;  // rw
    localparam cfg_addr_t REG_G_SHIFT     = 3'd4;  // rw
    localparam cfg_addr_t REG_RATE_RESET  = 3'd5;  // wo, pulse
    localparam cfg_addr_t REG_CUR_GAP     = 3'd6;  // ro, live
    localparam cfg_addr_t REG_ALPHA       = 3'd7;  // ro, live

    // reset values
    localparam gap_t      INIT_GAP_DEF    = 32'd100;
    localparam gap_t      MIN_GAP_DEF     = 32'd4;
    localparam gap_t      MAX_GAP_DEF     = 32'd4000;
    localparam cfg_data_t RECOVER_CNT_DEF = 32'd10;
    localparam shift_t    G_SHIFT_DEF     = 4'd4;

    // largest sensible gain exponent, beyond it alpha never moves
    localparam cfg_data_t G_SHIFT_MAX     = 32'd10;

endpackage

//--- logic/cc_rate_regs.sv
module cc_rate_regs import cc_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      cfg_wr,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata,

    input  gap_t      cur_gap,      // live, from rate control
    input  alpha_t    alpha,        // live, from rate control

    output gap_t      init_gap,
    output gap_t      min_gap,
    output gap_t      max_gap,
    output cfg_data_t recover_cnt,
    output shift_t    g_shift,
    output logic      rate_reset    // one cycle, the cycle after the write
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            init_gap    <= INIT_GAP_DEF;
            min_gap     <= MIN_GAP_DEF;
            max_gap     <= MAX_GAP_DEF;
            recover_cnt <= RECOVER_CNT_DEF;
            g_shift     <= G_SHIFT_DEF;
            rate_reset  <= 1'b0;
        end else begin
            rate_reset <= cfg_wr && (cfg_addr == REG_RATE_RESET);  // self clearing
            if (cfg_wr) begin
                case (cfg_addr)
                    REG_INIT_GAP:    init_gap    <= cfg_wdata;
                    REG_MIN_GAP:     min_gap     <= cfg_wdata;
                    REG_MAX_GAP:     max_gap     <= cfg_wdata;
                    REG_RECOVER_CNT: recover_cnt <= cfg_wdata;
                    REG_G_SHIFT:     g_shift     <= cfg_wdata[3:0];
                    default: ;                     // pulse and read-only addresses
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // readback, combinational from the address
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (cfg_addr)
            REG_INIT_GAP:    cfg_rdata = init_gap;
            REG_MIN_GAP:     cfg_rdata = min_gap;
            REG_MAX_GAP:     cfg_rdata = max_gap;
            REG_RECOVER_CNT: cfg_rdata = recover_cnt;
            REG_G_SHIFT:     cfg_rdata = cfg_data_t'(g_shift);  // zero extended
            REG_CUR_GAP:     cfg_rdata = cur_gap;
            REG_ALPHA:       cfg_rdata = cfg_data_t'(alpha);    // zero extended
            default:         cfg_rdata = '0;                    // rate reset reads 0
        endcase
    end

    // a shift above 10 leaves alpha frozen, software must not program it
    a_g_shift_range: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (cfg_wr && cfg_addr == REG_G_SHIFT) |-> (cfg_wdata <= G_SHIFT_MAX)
    ) else $error("g_shift written above %0d", G_SHIFT_MAX);

endmodule

//--- logic/cc_rate_ctrl.sv
module cc_rate_ctrl import cc_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    input  logic      ecn_valid,    // one strobe per cycle, always taken
    input  logic      ecn_mark,

    input  gap_t      init_gap,
    input  gap_t      min_gap,
    input  gap_t      max_gap,
    input  cfg_data_t recover_cnt,
    input  shift_t    g_shift,
    input  logic      rate_reset,

    output gap_t      cur_gap,
    output alpha_t    alpha
);

    gap_t        tgt_gap;           // target for halfway recovery
    cfg_data_t   unmarked_cnt;

    logic [42:0] gap_prod;          // cur_gap * alpha
    logic [32:0] raw_gap;           // one bit of headroom before clamping
    cfg_data_t   cnt_inc;
    logic        recover;

    gap_t        nxt_gap;
    gap_t        nxt_tgt;
    alpha_t      nxt_alpha;
    cfg_data_t   nxt_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state for one strobe
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign gap_prod = cur_gap * alpha;
    assign cnt_inc  = unmarked_cnt + 32'd1;
    assign recover  = (cnt_inc >= recover_cnt);   // >= also covers a lowered threshold

    always_comb begin
        nxt_tgt   = tgt_gap;
        nxt_alpha = alpha;
        nxt_cnt   = cnt_inc;
        raw_gap   = {1'b0, cur_gap};              // unchanged unless a rule fires
        if (ecn_mark) begin
            // congestion: gap grows by cur*alpha/2048, alpha moves toward 1
            nxt_tgt   = cur_gap;
            raw_gap   = {1'b0, cur_gap} + {1'b0, gap_prod[42:11]};
            nxt_alpha = alpha - (alpha >> g_shift) + (ALPHA_ONE >> g_shift);
            nxt_cnt   = '0;
        end else if (recover) begin
            // quiet long enough: halfway back to target, alpha decays
            raw_gap   = ({1'b0, cur_gap} + {1'b0, tgt_gap}) >> 1;
            nxt_alpha = alpha - (alpha >> g_shift);
            nxt_cnt   = '0;
        end

        // clamp into the configured window
        if (raw_gap < {1'b0, min_gap}) begin
            nxt_gap = min_gap;
        end else if (raw_gap > {1'b0, max_gap}) begin
            nxt_gap = max_gap;
        end else begin
            nxt_gap = raw_gap[31:0];
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn || rate_reset) begin          // both restart the estimate
            cur_gap      <= init_gap;
            tgt_gap      <= init_gap;
            alpha        <= ALPHA_ONE;
            unmarked_cnt <= '0;
        end else if (ecn_valid) begin
            cur_gap      <= nxt_gap;
            tgt_gap      <= nxt_tgt;
            alpha        <= nxt_alpha;
            unmarked_cnt <= nxt_cnt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_alpha_max: assert property (
        @(posedge aclk) disable iff (!aresetn)
        alpha <= ALPHA_ONE
    ) else $error("alpha above 1.0: %0d", alpha);

    // window is taken from the strobe cycle, a later cfg write may move it
    a_gap_window: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (ecn_valid && !rate_reset) |=>
            (cur_gap >= $past(min_gap)) && (cur_gap <= $past(max_gap))
    ) else $error("cur_gap %0d outside window after update", cur_gap);

endmodule

//--- logic/cc_pacer.sv
module cc_pacer import cc_pkg::*; (
    input  logic aclk,
    input  logic aresetn,

    input  gap_t cur_gap,

    input  logic s_req_valid,
    input  req_t s_req_data,
    output logic s_req_ready,       // single-cycle pulse per admission

    output logic enq_valid,
    output req_t enq_data,
    input  logic enq_ready          // low while the queue is full
);

    pacer_state_t state;
    gap_t         timer;            // cycles since last admission
    logic         admit_ok;

    // gap elapsed, a request waiting, room downstream
    assign admit_ok = (timer >= cur_gap) && s_req_valid && enq_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_WAIT_GAP;
            timer <= '0;
        end else begin
            case (state)
                ST_WAIT_GAP: begin
                    if (admit_ok) state <= ST_ADMIT;
                    if (timer != '1) timer <= timer + 32'd1;  // saturate, no wrap
                end
                ST_ADMIT: begin
                    state <= ST_WAIT_GAP;
                    timer <= '0;                              // restart spacing
                end
                default: state <= ST_WAIT_GAP;
            endcase
        end
    end

    // requester holds valid and data until ready, so the admit cycle
    // still sees the request chosen in the wait cycle
    assign s_req_ready = (state == ST_ADMIT);
    assign enq_valid   = (state == ST_ADMIT);
    assign enq_data    = s_req_data;          // straight through, stable under valid

endmodule

//--- logic/req_queue.sv
module req_queue import cc_pkg::*; (
    input  logic aclk,
    input  logic aresetn,

    input  logic enq_valid,
    input  req_t enq_data,
    output logic enq_ready,

    output logic m_req_valid,       // registered
    output req_t m_req_data,        // registered
    input  logic m_req_ready
);

    req_t                 mem [REQ_QDEPTH];
    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_PTR_W:0]   mem_cnt;  // entries behind the output register

    logic enq;
    logic out_free;                 // output register can take a new head
    logic mem_empty;
    logic mem_wr;
    logic mem_rd;

    assign enq_ready = (mem_cnt != REQ_QDEPTH[REQ_PTR_W:0]);
    assign enq       = enq_valid && enq_ready;
    assign out_free  = !m_req_valid || m_req_ready;
    assign mem_empty = (mem_cnt == '0);
    assign mem_rd    = out_free && !mem_empty;
    assign mem_wr    = enq && !(out_free && mem_empty);  // else bypass to output

    // storage, no reset on payload
    always_ff @(posedge aclk) begin
        if (mem_wr) mem[wr_ptr] <= enq_data;
        if (mem_rd) begin
            m_req_data <= mem[rd_ptr];   // oldest first
        end else if (out_free && enq) begin
            m_req_data <= enq_data;      // empty queue, one cycle to the sink
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            mem_cnt     <= '0;
            m_req_valid <= 1'b0;
        end else begin
            if (mem_wr) wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            if (mem_rd) rd_ptr <= rd_ptr + 1'b1;
            mem_cnt <= mem_cnt + mem_wr - mem_rd;
            if (out_free) m_req_valid <= !mem_empty || enq;  // head held otherwise
        end
    end

    // the pacer must look at enq_ready before it admits
    a_no_enq_full: assert property (
        @(posedge aclk) disable iff (!aresetn)
        enq_valid |-> enq_ready
    ) else $error("enqueue into a full request queue");

endmodule

//--- logic/cc_queue.sv
module cc_queue import cc_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,

    // ecn feedback, strobe only
    input  logic      ecn_valid,
    input  logic      ecn_mark,

    // configuration
    input  logic      cfg_wr,
    input  cfg_addr_t cfg_addr,
    input  cfg_data_t cfg_wdata,
    output cfg_data_t cfg_rdata,

    // requests in
    input  logic      s_req_valid,
    output logic      s_req_ready,
    input  req_t      s_req_data,

    // requests out
    output logic      m_req_valid,
    input  logic      m_req_ready,
    output req_t      m_req_data
);

    // config toward rate control
    gap_t      init_gap;
    gap_t      min_gap;
    gap_t      max_gap;
    cfg_data_t recover_cnt;
    shift_t    g_shift;
    logic      rate_reset;

    // live rate state
    gap_t      cur_gap;
    alpha_t    alpha;

    // pacer to queue
    logic      enq_valid;
    logic      enq_ready;
    req_t      enq_data;

    cc_rate_regs cc_rate_regs_i (
        .aclk, .aresetn,
        .cfg_wr, .cfg_addr, .cfg_wdata, .cfg_rdata,
        .cur_gap, .alpha,
        .init_gap, .min_gap, .max_gap, .recover_cnt, .g_shift, .rate_reset
    );

    cc_rate_ctrl cc_rate_ctrl_i (
        .aclk, .aresetn,
        .ecn_valid, .ecn_mark,
        .init_gap, .min_gap, .max_gap, .recover_cnt, .g_shift, .rate_reset,
        .cur_gap, .alpha
    );

    cc_pacer cc_pacer_i (
        .aclk, .aresetn,
        .cur_gap,
        .s_req_valid, .s_req_data, .s_req_ready,
        .enq_valid, .enq_data, .enq_ready
    );

    req_queue req_queue_i (
        .aclk, .aresetn,
        .enq_valid, .enq_data, .enq_ready,
        .m_req_valid, .m_req_data, .m_req_ready
    );

endmodule

//--- dv/tb_cc_queue.sv
module tb_cc_queue import cc_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;   // cycles per handshake before giving up

    logic      aclk = 1'b0;
    logic      aresetn;
    logic      ecn_valid;
    logic      ecn_mark;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_wdata;
    cfg_data_t cfg_rdata;
    logic      s_req_valid;
    logic      s_req_ready;
    req_t      s_req_data;
    logic      m_req_valid;
    logic      m_req_ready;
    req_t      m_req_data;

    int    mismatch_cnt = 0;
    int    other_cnt    = 0;
    int    cycle_cnt    = 0;
    string test_name    = "none";
    gap_t  exp_gap      = INIT_GAP_DEF;  // last gap the data file expected

    always #10 aclk = ~aclk;
    always @(posedge aclk) cycle_cnt <= cycle_cnt + 1;

    cc_queue cc_queue_i (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_gap(input string name, input gap_t exp_v, input gap_t act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: gap expected %0d, actual %0d", name, exp_v, act_v);
            mismatch_cnt++;
        end
    endtask

    task automatic check_alpha(input string name, input alpha_t exp_v, input alpha_t act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: alpha expected %0d, actual %0d", name, exp_v, act_v);
            mismatch_cnt++;
        end
    endtask

    task automatic check_req(input string name, input req_t exp_v, input req_t act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: request expected %h, actual %h", name, exp_v, act_v);
            mismatch_cnt++;
        end
    endtask

    task automatic check_reg(input string name, input cfg_data_t exp_v, input cfg_data_t act_v);
        if (act_v !== exp_v) begin
            $display("Mismatch %s: register expected %0d, actual %0d", name, exp_v, act_v);
            mismatch_cnt++;
        end
    endtask

    // descriptor n of a burst with both halves varying in n
    function automatic req_t make_req(input int unsigned seq);
        return {seq, ~seq};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus tasks that drive at +2 and sample mid cycle at +10
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        @(posedge aclk);
        #2;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge aclk);            // write edge
        #2;
        cfg_wr = 1'b0;
    endtask

    task automatic read_reg(input cfg_addr_t addr, output cfg_data_t data);
        @(posedge aclk);
        #2;
        cfg_addr = addr;
        #8;
        data = cfg_rdata;           // combinational readback
    endtask

    task automatic ecn_strobes(input logic mark, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            @(posedge aclk);
            #2;
            ecn_valid = 1'b1;       // back to back strobes
            ecn_mark  = mark;
        end
        @(posedge aclk);
        #2;
        ecn_valid = 1'b0;
        ecn_mark  = 1'b0;
    endtask

    task automatic send_reqs(input int count, input int unsigned base);
        int i;
        int wait_cnt;
        for (i = 0; i < count; i++) begin
            @(posedge aclk);
            #2;
            s_req_valid = 1'b1;
            s_req_data  = make_req(base + i);   // held until ready
            #8;
            wait_cnt = 0;
            while (!s_req_ready && wait_cnt < WAIT_LIMIT) begin
                @(posedge aclk);
                #10;
                wait_cnt++;
            end
            if (!s_req_ready) begin
                $display("%s: timed out waiting for s_req_ready on request %0d", test_name, i);
                other_cnt++;
                break;
            end
        end
        @(posedge aclk);
        #2;
        s_req_valid = 1'b0;
    endtask

    task automatic recv_reqs(input int count, input int unsigned base, input logic rand_rdy);
        int got;
        int wait_cnt;
        int last_cyc;
        got      = 0;
        wait_cnt = 0;
        last_cyc = 0;
        while (got < count && wait_cnt < WAIT_LIMIT) begin
            @(posedge aclk);
            #2;
            // slow random sink so that entries pile up in the queue
            m_req_ready = rand_rdy ? (($urandom % 64) == 0) : 1'b1;
            #8;
            wait_cnt++;
            if (m_req_valid && m_req_ready) begin
                check_req(test_name, make_req(base + got), m_req_data);
                if (!rand_rdy && got > 0 && (cycle_cnt - last_cyc) < int'(exp_gap)) begin
                    $display("%s: transfers only %0d cycles apart, gap is %0d",
                             test_name, cycle_cnt - last_cyc, exp_gap);
                    other_cnt++;
                end
                last_cyc = cycle_cnt;
                got++;
                wait_cnt = 0;
            end
        end
        if (got < count) begin
            $display("%s: timed out, only %0d of %0d requests came out", test_name, got, count);
            other_cnt++;
        end
        m_req_ready = 1'b1;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command loop over the data file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int        fd;
        string     line;
        byte       cmd;
        int        arg_a;
        int        arg_b;
        int        arg_c;
        cfg_data_t rd;
        aresetn     = 1'b0;
        ecn_valid   = 1'b0;
        ecn_mark    = 1'b0;
        cfg_wr      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        s_req_valid = 1'b0;
        s_req_data  = '0;
        m_req_ready = 1'b1;
        void'($urandom(32'h3017));      // one seed for the whole run
        repeat (4) @(posedge aclk);
        #2;
        aresetn = 1'b1;

        fd = $fopen("dv/cc_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/cc_testdata.txt");
            other_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0) continue;
                cmd   = line[0];
                arg_c = 0;
                if (cmd == "T") begin
                    void'($sscanf(line, "%c %s", cmd, test_name));
                end else begin
                    void'($sscanf(line, "%c %d %d %d", cmd, arg_a, arg_b, arg_c));
                end
                case (cmd)
                    "W": write_reg(cfg_addr_t'(arg_a), cfg_data_t'(arg_b));
                    "E": ecn_strobes(arg_a[0], arg_b);
                    "R": begin
                        read_reg(cfg_addr_t'(arg_a), rd);
                        check_reg(test_name, cfg_data_t'(arg_b), rd);
                    end
                    "G": begin
                        exp_gap = gap_t'(arg_a);
                        read_reg(REG_CUR_GAP, rd);
                        check_gap(test_name, exp_gap, gap_t'(rd));
                    end
                    "A": begin
                        read_reg(REG_ALPHA, rd);
                        check_alpha(test_name, alpha_t'(arg_a), alpha_t'(rd[10:0]));
                    end
                    "S": fork
                        send_reqs(arg_a, arg_b);
                        recv_reqs(arg_a, arg_b, arg_c[0]);
                    join
                    default: ;      // comments and blank lines
                endcase
            end
            $fclose(fd);
        end

        $display("error count: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- dv/cc_testdata.txt
# T name | W addr data | E mark count | R addr value | G gap | A alpha
# S count base rand_ready (1 random sink ready, 0 always ready); all numbers decimal
T reset_defaults
R 0 100
R 1 4
R 2 4000
R 3 10
R 4 4
R 5 0
G 100
A 1024
T marked_growth
E 1 1
G 150
A 1024
E 1 2
G 337
A 1024
T unmarked_recovery
E 0 9
G 337
A 1024
E 0 1
G 281
A 960
E 1 1
G 412
A 964
T clamp_at_max
W 2 500
R 2 500
E 1 1
G 500
A 968
E 0 10
G 456
A 908
T rate_reset
W 0 40
W 5 1
G 40
A 1024
T order_backpressure
S 12 4096 1
T spacing_ready
W 0 6
W 5 1
G 6
S 8 8192 0

//--- all.f
logic/cc_pkg.sv
logic/cc_rate_regs.sv
logic/cc_rate_ctrl.sv
logic/cc_pacer.sv
logic/req_queue.sv
logic/cc_queue.sv
dv/tb_cc_queue.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_cc_queue -o sim_cc_queue
./obj_dir/sim_cc_queue > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
